// File: pixelPack.f
rtl/pixelPkg.sv
rtl/fifoPkg.sv
rtl/fetchIf.sv
rtl/wordFifo.sv
rtl/fetchFsm.sv
rtl/sliceCounter.sv
rtl/sliceShifter.sv
rtl/pixelPacker.sv
+incdir+test
test/tbPixelPacker.sv

// File: run.sh
#!/usr/bin/env bash
# build the pixel packer testbench with Verilator, run it, then check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbPixelPacker -f pixelPack.f -o simPixelPacker \
	&& ./obj_dir/simPixelPacker > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "TESTS PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }

// File: test/tbChecks.svh
// testbench checks
// typed compares, bounded waits and stop at the first error
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// reporting
// ------------------------------
task automatic failStop(input string why);
begin
	$display("%s", why);						// what went wrong
	$display("TESTS FAILED");
	$fatal(1, "run stopped at first error");
end
endtask

task automatic checkPixel(input string name, input pixelT got, input pixelT exp);
begin
	if (got !== exp)
		failStop($sformatf("ERR %s got %h expected %h", name, got, exp));
end
endtask

task automatic checkFlag(input string name, input logic got, input logic exp);
begin
	if (got !== exp)
		failStop($sformatf("ERR %s got %h expected %h", name, got, exp));
end
endtask

// ------------------------------
// bounded waits
// ------------------------------
task automatic waitPixWe(input logic lvl, input int limit);
	int n;
begin
	n = 0;
	while (pixWe !== lvl)
	begin
		if (n == limit)
			failStop($sformatf("timeout waiting for pixWe to become %0d", lvl));
		@(negedge iCLK);
		n++;
	end
end
endtask

`endif

// File: test/tbPixelPacker.sv
// pixel packer testbench
// directed tests of the word fifo to pixel path against a reference pixel queue
`default_nettype none

module tbPixelPacker
	import pixelPkg::*;
	import fifoPkg::*;
();

	logic		iCLK;
	logic		iRST;
	logic		wrEn;
	pixelWordT	wrData;
	logic		full;
	pixelT		pixData;
	logic		pixWe;
	logic		pixAccept;

	pixelT		refQ [$];						// expected pixels in output order
	pixelWordT	pendQ [$];						// words the drain loop writes
	integer		seed;

	pixelPacker pixelPacker_i (
		.iCLK		(iCLK),
		.iRST		(iRST),
		.wrEn		(wrEn),
		.wrData		(wrData),
		.full		(full),
		.pixData	(pixData),
		.pixWe		(pixWe),
		.pixAccept	(pixAccept)
	);

	always #5 iCLK = ~iCLK;

	`include "tbChecks.svh"

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic pushRef(input pixelWordT w);
		int i;
	begin
		for (i = 0; i < SLICES; i++)
			refQ.push_back(w.raw[i*PIX_W +: PIX_W]);	// low 16 bits go first
	end
	endtask

	function automatic pixelWordT randWord();
		pixelWordT w;
	begin
		w.raw = {$random(seed), $random(seed)};
		return w;
	end
	endfunction

	task automatic writeWord(input pixelWordT w, input bit keep);
	begin
		wrEn	= 1'b1;
		wrData	= w;
		if (keep)
			pushRef(w);							// dropped words expect nothing
		@(negedge iCLK);
		wrEn	= 1'b0;
	end
	endtask

	// writes pendQ one word per cycle while taking and checking pixels
	task automatic drainPixels(input int count, input bit randAcc);
		int		got;
		int		n;
		int		r;
		logic	prevStall;
		pixelT	prevData;
	begin
		got			= 0;
		n			= 0;
		prevStall	= 1'b0;
		prevData	= '0;
		while (got < count)
		begin
			if (n == count * 16 + 64)
				failStop("timeout while draining pixels");
			if (prevStall)
			begin
				checkFlag("pixWe", pixWe, 1'b1);			// no drop during a stall
				checkPixel("pixData", pixData, prevData);	// no change during a stall
			end
			wrEn = (pendQ.size() != 0);
			if (wrEn)
			begin
				wrData = pendQ.pop_front();
				pushRef(wrData);
			end
			r			= $random(seed);
			pixAccept	= randAcc ? r[0] : 1'b1;
			if (pixWe && pixAccept)
			begin
				if (refQ.size() == 0)
					failStop("pixel written with no pixel expected");
				checkPixel("pixData", pixData, refQ.pop_front());
				got++;
			end
			prevStall	= pixWe & ~pixAccept;
			prevData	= pixData;
			@(negedge iCLK);
			n++;
		end
		wrEn		= 1'b0;
		pixAccept	= 1'b0;
	end
	endtask

	// strobe must fall and no stray word may follow
	task automatic endCheck();
	begin
		if (refQ.size() != 0)
			failStop("expected pixels left over after drain");
		waitPixWe(1'b0, 4);
		repeat (12)
		begin
			checkFlag("pixWe", pixWe, 1'b0);
			@(negedge iCLK);
		end
	end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic testResetIdle();
	begin
		repeat (20)
		begin
			checkFlag("pixWe", pixWe, 1'b0);
			checkFlag("full", full, 1'b0);
			@(negedge iCLK);
		end
	end
	endtask

	task automatic testOneWord();
	begin
		pendQ.push_back(randWord());
		drainPixels(SLICES, 1'b0);
		endCheck();
	end
	endtask

	task automatic testRandomAccept();
	begin
		repeat (5)
			pendQ.push_back(randWord());
		drainPixels(5 * SLICES, 1'b1);
		endCheck();
	end
	endtask

	task automatic testFull();
		int k;
	begin
		pixAccept = 1'b0;
		writeWord(randWord(), 1'b1);
		waitPixWe(1'b1, 16);					// first word parks in the shifter
		for (k = 1; k <= FIFO_DEPTH; k++)
		begin
			writeWord(randWord(), 1'b1);
			checkFlag("full", full, k == FIFO_DEPTH);
		end
		writeWord(randWord(), 1'b0);			// must be dropped
		checkFlag("full", full, 1'b1);
		drainPixels((FIFO_DEPTH + 1) * SLICES, 1'b0);
		endCheck();
		checkFlag("full", full, 1'b0);
	end
	endtask

	task automatic testBackToBack();
	begin
		repeat (6)
			pendQ.push_back(randWord());
		drainPixels(6 * SLICES, 1'b0);
		endCheck();
	end
	endtask

	initial
	begin
		seed		= 32'h31a7_b329;
		iCLK		= 1'b0;
		iRST		= 1'b1;
		wrEn		= 1'b0;
		wrData		= '0;
		pixAccept	= 1'b0;
		repeat (8) @(negedge iCLK);
		iRST		= 1'b0;
		testResetIdle();
		testOneWord();
		testRandomAccept();
		testFull();
		testBackToBack();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/pixelPacker.sv
// pixel packer top
// 64-bit word fifo in, 16-bit pixels out, lowest slice first
`default_nettype none

module pixelPacker
	import pixelPkg::*;
(
	input  wire logic		iCLK,
	input  wire logic		iRST,
	// ------------------------------
	// write side
	// ------------------------------
	input  wire logic		wrEn,			// word write strobe
	input  wire pixelWordT	wrData,			// packed word
	output logic			full,			// fifo full
	// ------------------------------
	// pixel side
	// ------------------------------
	output pixelT			pixData,		// pixel out
	output logic			pixWe,			// pixel valid level
	input  wire logic		pixAccept		// sink accept level
);

	logic	busy;							// counter running flag
	logic	taken;							// slice consumed

	fetchIf fetchBus ();

	wordFifo wordFifo_i (
		.iCLK	(iCLK),
		.iRST	(iRST),
		.wrEn	(wrEn),
		.wrData	(wrData),
		.full	(full),
		.fetch	(fetchBus.fifo)
	);

	fetchFsm fetchFsm_i (
		.iCLK	(iCLK),
		.iRST	(iRST),
		.fetch	(fetchBus.fsm),
		.busy	(busy)
	);

	sliceCounter sliceCounter_i (
		.iCLK	(iCLK),
		.iRST	(iRST),
		.load	(fetchBus.rdValid),		// count restarts with each word
		.taken	(taken),
		.busy	(busy)
	);

	sliceShifter sliceShifter_i (
		.iCLK		(iCLK),
		.iRST		(iRST),
		.fetch		(fetchBus.shifter),
		.busy		(busy),
		.pixAccept	(pixAccept),
		.taken		(taken),
		.pixData	(pixData),
		.pixWe		(pixWe)
	);

endmodule

`default_nettype wire

// File: rtl/sliceShifter.sv
// slice shifter
// holds the fetched word and rotates out one 16-bit pixel per accepted slice
`default_nettype none

module sliceShifter
	import pixelPkg::*;
(
	input  wire logic	iCLK,
	input  wire logic	iRST,
	fetchIf.shifter		fetch,				// read valid and data
	input  wire logic	busy,				// word in progress
	input  wire logic	pixAccept,			// sink accept level
	output logic		taken,				// slice consumed this cycle
	output pixelT		pixData,			// current pixel
	output logic		pixWe				// pixel write strobe
);

	pixelT [SLICES-1:0]	pixReg;				// pixReg[0] is on the output

	// write strobe rises the cycle after load and drops with the last take
	assign pixWe	= busy;
	assign taken	= pixWe & pixAccept;
	assign pixData	= pixReg[0];

	// ------------------------------
	// pixel register
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (fetch.rdValid)
			pixReg <= fetch.rdData.pix;							// pixel view of the word
		else if (taken)
			pixReg <= {pixReg[0], pixReg[SLICES-1:1]};			// next pixel down
	end

	// ------------------------------
	// checks
	// ------------------------------
	aHoldStall: assert property (@(posedge iCLK) disable iff (iRST)
		pixWe && !pixAccept |=> pixWe && $stable(pixData))
		else $error("pixel changed while sink stalled");

	aFirstSlice: assert property (@(posedge iCLK) disable iff (iRST)
		fetch.rdValid |=> pixWe && (pixData == $past(fetch.rdData.pix[0])))
		else $error("slice 0 not presented after load");

endmodule

`default_nettype wire

// File: rtl/sliceCounter.sv
// slice counter
// counts the pixels left in the current word and flags a word in progress
`default_nettype none

module sliceCounter
	import pixelPkg::*;
(
	input  wire logic	iCLK,
	input  wire logic	iRST,
	input  wire logic	load,				// word fetched
	input  wire logic	taken,				// one pixel accepted
	output logic		busy				// word in progress
);

	logic [SLICE_CW-1:0]	count;			// slices left after the current one

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			count	<= '0;
			busy	<= 1'b0;
		end
		else if (load)
		begin
			count	<= SLICE_CW'(SLICES - 1);	// 3 more after slice 0
			busy	<= 1'b1;
		end
		else if (taken)
		begin
			if (count == '0)
				busy <= 1'b0;					// last slice gone
			else
				count <= count - 1'b1;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	aNoLoadBusy: assert property (@(posedge iCLK) disable iff (iRST)
		load |-> !busy)
		else $error("word loaded while previous word in progress");

endmodule

`default_nettype wire

// File: rtl/fetchFsm.sv
// fetch sequencer
// one read request per word, then waits for the fifo's read valid
`default_nettype none

module fetchFsm
	import fifoPkg::*;
(
	input  wire logic	iCLK,
	input  wire logic	iRST,
	fetchIf.fsm			fetch,				// fifo read side
	input  wire logic	busy				// word still being sliced
);

	logic [FETCH_SW-1:0]	state;
	logic					rdReqReg;		// registered request pulse
	logic					startCke;		// word waiting and shifter free

	assign startCke		= fetch.notEmpty & ~busy;
	assign fetch.rdReq	= rdReqReg;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state		<= ST_IDLE;
			rdReqReg	<= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					state		<= startCke ? ST_REQ : ST_IDLE;
					rdReqReg	<= startCke;				// pulse next cycle
				end
				ST_REQ:
				begin
					state		<= ST_WAIT;
					rdReqReg	<= 1'b0;					// single-cycle request
				end
				ST_WAIT:
				begin
					state		<= fetch.rdValid ? ST_IDLE : ST_WAIT;
					rdReqReg	<= 1'b0;
				end
				default:
				begin
					state		<= ST_IDLE;
					rdReqReg	<= 1'b0;
				end
			endcase
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	aWaitAnswered: assert property (@(posedge iCLK) disable iff (iRST)
		state == ST_WAIT |-> fetch.rdValid)
		else $error("read request left unanswered");

	aValidAfterReq: assert property (@(posedge iCLK) disable iff (iRST)
		fetch.rdValid |-> $past(state) == ST_REQ)
		else $error("read valid without a pending request");

endmodule

`default_nettype wire

// File: rtl/wordFifo.sv
// input word fifo
// single clock, eight 64-bit words, registered read port and full flag
`default_nettype none

module wordFifo
	import pixelPkg::*;
	import fifoPkg::*;
(
	input  wire logic		iCLK,
	input  wire logic		iRST,
	input  wire logic		wrEn,			// write strobe from upstream
	input  wire pixelWordT	wrData,			// packed word in raw view
	output logic			full,			// writes dropped while high
	fetchIf.fifo			fetch			// read side
);

	logic [WORD_W-1:0]	mem [FIFO_DEPTH];	// word storage
	fifoPtrT			wrPtr;				// next slot to write
	fifoPtrT			rdPtr;				// next slot to read
	fifoPtrT			used;				// occupancy
	pixelWordT			rdWord;				// registered read data
	logic				rdValidReg;			// read answer pulse
	logic				wrOk;				// accepted write

	assign used				= wrPtr - rdPtr;
	assign full				= (used == fifoPtrT'(FIFO_DEPTH));	// rises with the 8th store
	assign wrOk				= wrEn & ~full;						// drop when full
	assign fetch.notEmpty	= (used != '0);
	assign fetch.rdData		= rdWord;
	assign fetch.rdValid	= rdValidReg;

	// ------------------------------
	// storage and read register
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (wrOk)
			mem[wrPtr[FIFO_AW-1:0]] <= wrData.raw;	// stored as raw word
		if (fetch.rdReq)
			rdWord.raw <= mem[rdPtr[FIFO_AW-1:0]];	// data lands with rdValid
	end

	// ------------------------------
	// pointers
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr		<= '0;
			rdPtr		<= '0;
			rdValidReg	<= 1'b0;
		end
		else
		begin
			if (wrOk)
				wrPtr <= wrPtr + 1'b1;
			if (fetch.rdReq)
				rdPtr <= rdPtr + 1'b1;
			rdValidReg <= fetch.rdReq;				// one answer per request
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	aNoReadEmpty: assert property (@(posedge iCLK) disable iff (iRST)
		fetch.rdReq |-> fetch.notEmpty)
		else $error("fifo read requested while empty");

	aNoOverflow: assert property (@(posedge iCLK) disable iff (iRST)
		used <= fifoPtrT'(FIFO_DEPTH))
		else $error("fifo occupancy beyond depth");

endmodule

`default_nettype wire

// File: rtl/fetchIf.sv
// fifo read bus
// read request, read valid, read data and not-empty between the word fifo,
// the fetch fsm and the slice shifter
`default_nettype none

interface fetchIf
	import pixelPkg::*;
();

	logic		rdReq;					// one-cycle pulse from fsm to fifo
	logic		rdValid;				// one-cycle pulse on the edge after rdReq
	pixelWordT	rdData;					// valid with rdValid
	logic		notEmpty;				// fifo holds at least one word

	// ------------------------------
	// views
	// ------------------------------
	modport fifo	(input rdReq, output rdValid, output rdData, output notEmpty);
	modport fsm		(output rdReq, input rdValid, input notEmpty);
	modport shifter	(input rdValid, input rdData);

endinterface

`default_nettype wire

// File: rtl/fifoPkg.sv
// input fifo package
// word fifo depth, pointer type and the fetch sequencer state codes
`default_nettype none

package fifoPkg;

	localparam int FIFO_DEPTH = 8;				// words
	localparam int FIFO_AW    = 3;				// storage address bits

	typedef logic [FIFO_AW:0] fifoPtrT;			// extra msb splits full from empty

	localparam int FETCH_SW = 2;				// fetch state width
	localparam logic [FETCH_SW-1:0] ST_IDLE = 2'd0;	// waiting for a word
	localparam logic [FETCH_SW-1:0] ST_REQ  = 2'd1;	// read request out
	localparam logic [FETCH_SW-1:0] ST_WAIT = 2'd2;	// waiting for read valid

endpackage

`default_nettype wire

// File: rtl/pixelPkg.sv
// pixel path package
// pixel and word widths plus the packed word that carries four pixels
`default_nettype none

package pixelPkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int PIX_W    = 16;				// one output pixel
	localparam int WORD_W   = 64;				// one fifo word
	localparam int SLICES   = WORD_W / PIX_W;		// pixels per word
	localparam int SLICE_CW = $clog2(SLICES);		// remaining-slice counter

	typedef logic [PIX_W-1:0] pixelT;			// one pixel on the sink side

	// ------------------------------
	// packed word
	// ------------------------------
	// written as raw data, read back as four pixels
	typedef union packed
	{
		logic [WORD_W-1:0]	raw;			// fifo storage and write port
		pixelT [SLICES-1:0]	pix;			// pix[0] is bits 15:0
	} pixelWordT;

endpackage

`default_nettype wire
